// File: testbench/issue_testdata.txt
// flush v0 inst0 pc0 iid0 v1 inst1 pc1 iid1 out_ready, then expected in_ready
// v0 iid0 pc0 inst0 v1 iid1 pc1 inst1; all hex, one line per clock cycle
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04221800 0100 01 1 04853000 0104 02 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 01 0100 04221800 1 02 0104 04853000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04221800 0108 03 1 04623800 010c 04 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 03 0108 04221800 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 04 010c 04623800 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 8c280000 0110 05 1 8c490004 0114 06 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 05 0110 8c280000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 06 0114 8c490004 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 28225000 0118 07 1 8c8b0008 011c 08 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 08 011c 8c8b0008 1 07 0118 28225000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04000800 0120 09 1 04001000 0124 0a 0  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04001800 0128 0b 1 04002000 012c 0c 0  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04002800 0130 0d 1 04003000 0134 0e 0  1 1 09 0120 04000800 1 0a 0124 04001000
0 1 04003800 0138 0f 1 04004000 013c 10 0  1 1 09 0120 04000800 1 0a 0124 04001000
0 1 04004800 0140 11 1 04005000 0144 12 0  1 1 09 0120 04000800 1 0a 0124 04001000
0 0 00000000 0000 00 0 00000000 0000 00 0  0 1 09 0120 04000800 1 0a 0124 04001000
0 0 00000000 0000 00 0 00000000 0000 00 1  0 1 09 0120 04000800 1 0a 0124 04001000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 0b 0128 04001800 1 0c 012c 04002000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 0d 0130 04002800 1 0e 0134 04003000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 0f 0138 04003800 1 10 013c 04004000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 1 11 0140 04004800 1 12 0144 04005000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04000800 0148 13 1 04001000 014c 14 1  1 0 00 0000 00000000 0 00 0000 00000000
0 1 04001800 0150 15 1 04002000 0154 16 1  1 0 00 0000 00000000 0 00 0000 00000000
1 1 04002800 0158 17 1 04003000 015c 18 1  1 1 13 0148 04000800 1 14 014c 04001000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000
0 0 00000000 0000 00 0 00000000 0000 00 1  1 0 00 0000 00000000 0 00 0000 00000000

// File: tb.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/operand_decode.sv
rtl/issue_window.sv
rtl/pair_hazard.sv
rtl/issue_select.sv
rtl/issue_stage.sv
testbench/issue_stage_tb.sv

// File: testbench/issue_stage_tb.sv
module issue_stage_tb;
  import isa_pkg::*;
  import issue_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int MAX_LINES  = 64;
  localparam int NUM_COLS   = 19;
  localparam     DATA_FILE  = "testbench/issue_testdata.txt";

  logic  clk = 1'b0;
  logic  rst_n;
  logic  flush;
  logic  in_valid0;
  logic  in_valid1;
  inst_t in_inst0;
  inst_t in_inst1;
  pc_t   in_pc0;
  pc_t   in_pc1;
  iid_t  in_iid0;
  iid_t  in_iid1;
  logic  in_ready;
  logic  out_valid0;
  logic  out_valid1;
  inst_t out_inst0;
  inst_t out_inst1;
  pc_t   out_pc0;
  pc_t   out_pc1;
  iid_t  out_iid0;
  iid_t  out_iid1;
  logic  out_ready;

  // one row per cycle, columns as in the data file.
  logic [31:0] rows [MAX_LINES][NUM_COLS];
  int          line_cnt    = 0;
  logic        data_loaded = 1'b0;
  int          err_hs      = 0;
  int          err_data    = 0;
  int          err_file    = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  issue_stage uut (.*);

  ////////////////////////////////////////////////////////////
  // compare tasks.
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      err_hs++;
    end
  endtask

  task automatic check_iid(input string name, input iid_t exp, input iid_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_data++;
    end
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_data++;
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      err_data++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // data file, comment lines scan as zero fields.
  task load_data();
    int               fd;
    int               cnt;
    logic [8*160-1:0] line_buf;
    logic [31:0]      fld [NUM_COLS];
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the data file %s", DATA_FILE);
      err_file++;
      return;
    end
    while (!$feof(fd) && line_cnt < MAX_LINES) begin
      line_buf = '0;
      cnt = $fgets(line_buf, fd);
      cnt = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                    fld[15], fld[16], fld[17], fld[18]);
      if (cnt == NUM_COLS) begin
        for (int k = 0; k < NUM_COLS; k++) begin
          rows[line_cnt][k] = fld[k];
        end
        line_cnt++;
      end else if (cnt > 0) begin
        $display("data line after row %0d holds only %0d fields", line_cnt, cnt);
        err_file++;
      end
    end
    $fclose(fd);
    if (line_cnt == 0) begin
      $display("the data file holds no test lines");
      err_file++;
    end
  endtask

  task drive_line(input int n);
    flush     <= rows[n][0][0];
    in_valid0 <= rows[n][1][0];
    in_inst0  <= inst_t'(rows[n][2]);
    in_pc0    <= pc_t'(rows[n][3]);
    in_iid0   <= iid_t'(rows[n][4]);
    in_valid1 <= rows[n][5][0];
    in_inst1  <= inst_t'(rows[n][6]);
    in_pc1    <= pc_t'(rows[n][7]);
    in_iid1   <= iid_t'(rows[n][8]);
    out_ready <= rows[n][9][0];
  endtask

  task check_line(input int n);
    check_bit("in_ready", rows[n][10][0], in_ready);
    check_bit("out_valid0", rows[n][11][0], out_valid0);
    check_bit("out_valid1", rows[n][15][0], out_valid1);
    if (rows[n][11][0]) begin // lane fields only matter when valid.
      check_iid("out_iid0", iid_t'(rows[n][12]), out_iid0);
      check_pc("out_pc0", pc_t'(rows[n][13]), out_pc0);
      check_inst("out_inst0", inst_t'(rows[n][14]), out_inst0);
    end
    if (rows[n][15][0]) begin
      check_iid("out_iid1", iid_t'(rows[n][16]), out_iid1);
      check_pc("out_pc1", pc_t'(rows[n][17]), out_pc1);
      check_inst("out_inst1", inst_t'(rows[n][18]), out_inst1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence.
  initial begin
    rst_n     <= 1'b0;
    flush     <= 1'b0;
    in_valid0 <= 1'b0;
    in_valid1 <= 1'b0;
    in_inst0  <= '0;
    in_inst1  <= '0;
    in_pc0    <= '0;
    in_pc1    <= '0;
    in_iid0   <= '0;
    in_iid1   <= '0;
    out_ready <= 1'b1;
    load_data();
    data_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < line_cnt; n++) begin
      @(posedge clk);
      drive_line(n);
      @(negedge clk); // outputs settled.
      check_line(n);
    end
    @(posedge clk);
    $display("errors: %0d handshake, %0d data, %0d file", err_hs, err_data, err_file);
    if (err_hs + err_data + err_file == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    wait (data_loaded);
    #((line_cnt + RST_CYCLES) * CLK_PERIOD + 100);
    $display("timeout at %0t, the data lines were not all applied", $time);
    $display("sim failed");
    $finish;
  end

endmodule

// File: rtl/issue_stage.sv
`include "issue_settings.svh"

module issue_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 in_valid0,
  input  logic                 in_valid1,
  input  isa_pkg::inst_t       in_inst0,
  input  isa_pkg::inst_t       in_inst1,
  input  issue_pkg::pc_t       in_pc0,
  input  issue_pkg::pc_t       in_pc1,
  input  issue_pkg::iid_t      in_iid0,
  input  issue_pkg::iid_t      in_iid1,
  output logic                 in_ready,
  output logic                 out_valid0,
  output logic                 out_valid1,
  output isa_pkg::inst_t       out_inst0,
  output isa_pkg::inst_t       out_inst1,
  output issue_pkg::pc_t       out_pc0,
  output issue_pkg::pc_t       out_pc1,
  output issue_pkg::iid_t      out_iid0,
  output issue_pkg::iid_t      out_iid1,
  input  logic                 out_ready
);
  import isa_pkg::*;
  import issue_pkg::*;

  logic [`ISSUE_DEPTH-1:0] entry_valid;
  inst_t                   entry_inst [`ISSUE_DEPTH];
  pc_t                     entry_pc   [`ISSUE_DEPTH];
  iid_t                    entry_iid  [`ISSUE_DEPTH];
  reg_idx_t                src0       [`ISSUE_DEPTH];
  reg_idx_t                src1       [`ISSUE_DEPTH];
  reg_idx_t                dest       [`ISSUE_DEPTH];
  reg_use_t                use_mask   [`ISSUE_DEPTH];
  pipe_class_t             pipe_class [`ISSUE_DEPTH];
  logic [`ISSUE_DEPTH-1:0] is_branch;
  logic [`ISSUE_DEPTH-1:0] is_cmp;
  logic [`ISSUE_DEPTH-1:0] eligible;
  logic                    pop0;
  logic                    pop1;
  slot_idx_t               pop_slot0;
  slot_idx_t               pop_slot1;

  issue_window u_window (.*);

  // one decoder per window slot.
  for (genvar i = 0; i < `ISSUE_DEPTH; i++) begin : g_decode
    operand_decode u_decode (
      .inst       (entry_inst[i]),
      .src0       (src0[i]),
      .src1       (src1[i]),
      .dest       (dest[i]),
      .use_mask   (use_mask[i]),
      .pipe_class (pipe_class[i]),
      .is_branch  (is_branch[i]),
      .is_cmp     (is_cmp[i])
    );
  end

  pair_hazard u_hazard (.*);

  issue_select u_select (.*);

endmodule

// File: rtl/issue_select.sv
`include "issue_settings.svh"

module issue_select (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic [`ISSUE_DEPTH-1:0] eligible,
  input  isa_pkg::pipe_class_t    pipe_class [`ISSUE_DEPTH],
  input  isa_pkg::inst_t          entry_inst [`ISSUE_DEPTH],
  input  issue_pkg::pc_t          entry_pc   [`ISSUE_DEPTH],
  input  issue_pkg::iid_t         entry_iid  [`ISSUE_DEPTH],
  input  logic                    out_ready,
  output logic                    pop0,
  output logic                    pop1,
  output issue_pkg::slot_idx_t    pop_slot0,
  output issue_pkg::slot_idx_t    pop_slot1,
  output logic                    out_valid0,
  output logic                    out_valid1,
  output isa_pkg::inst_t          out_inst0,
  output isa_pkg::inst_t          out_inst1,
  output issue_pkg::pc_t          out_pc0,
  output issue_pkg::pc_t          out_pc1,
  output issue_pkg::iid_t         out_iid0,
  output issue_pkg::iid_t         out_iid1
);
  import isa_pkg::*;
  import issue_pkg::*;

  logic [`ISSUE_DEPTH-1:0] second_mask;
  logic                    pick0_vld;
  logic                    pick1_vld;
  slot_idx_t               pick0_slot;
  slot_idx_t               pick1_slot;
  pipe_class_t             pick0_pipe;
  logic                    swap;
  logic                    lane0_vld;
  logic                    lane1_vld;
  slot_idx_t               lane0_slot;
  slot_idx_t               lane1_slot;
  logic                    load_en;

  function automatic slot_idx_t oldest_slot(input logic [`ISSUE_DEPTH-1:0] mask);
    slot_idx_t slot;
    slot = '0;
    for (int i = `ISSUE_DEPTH - 1; i >= 0; i--) begin
      if (mask[i]) slot = slot_idx_t'(i);
    end
    return slot;
  endfunction

  ////////////////////////////////////////////////////////////
  // two picks, second one avoids a pipe clash.
  assign pick0_vld  = |eligible;
  assign pick0_slot = oldest_slot(eligible);
  assign pick0_pipe = pipe_class[pick0_slot];

  always_comb begin
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      second_mask[i] = eligible[i] && (slot_idx_t'(i) != pick0_slot) &&
                       !(pipe_class[i] == pick0_pipe && pick0_pipe != PIPE_ANY);
    end
  end

  assign pick1_vld  = |second_mask;
  assign pick1_slot = oldest_slot(second_mask);

  // memory goes to lane 0, branch to lane 1.
  assign swap = (pick1_vld && pipe_class[pick1_slot] == PIPE_MEMORY) ||
                (pick0_vld && pick0_pipe == PIPE_BRANCH);

  assign lane0_vld  = swap ? pick1_vld  : pick0_vld;
  assign lane1_vld  = swap ? pick0_vld  : pick1_vld;
  assign lane0_slot = swap ? pick1_slot : pick0_slot;
  assign lane1_slot = swap ? pick0_slot : pick1_slot;

  ////////////////////////////////////////////////////////////
  // output registers, pop on the loading edge.
  assign load_en   = out_ready || !(out_valid0 || out_valid1);
  assign pop0      = load_en && pick0_vld;
  assign pop1      = load_en && pick1_vld;
  assign pop_slot0 = pick0_slot;
  assign pop_slot1 = pick1_slot;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      out_valid0 <= 1'b0;
      out_valid1 <= 1'b0;
    end else if (load_en) begin
      out_valid0 <= lane0_vld;
      out_valid1 <= lane1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      out_inst0 <= entry_inst[lane0_slot];
      out_pc0   <= entry_pc[lane0_slot];
      out_iid0  <= entry_iid[lane0_slot];
      out_inst1 <= entry_inst[lane1_slot];
      out_pc1   <= entry_pc[lane1_slot];
      out_iid1  <= entry_iid[lane1_slot];
    end
  end

endmodule

// File: rtl/pair_hazard.sv
`include "issue_settings.svh"

module pair_hazard (
  input  logic [`ISSUE_DEPTH-1:0] entry_valid,
  input  isa_pkg::reg_idx_t       src0      [`ISSUE_DEPTH],
  input  isa_pkg::reg_idx_t       src1      [`ISSUE_DEPTH],
  input  isa_pkg::reg_idx_t       dest      [`ISSUE_DEPTH],
  input  isa_pkg::reg_use_t       use_mask  [`ISSUE_DEPTH],
  input  logic [`ISSUE_DEPTH-1:0] is_branch,
  input  logic [`ISSUE_DEPTH-1:0] is_cmp,
  output logic [`ISSUE_DEPTH-1:0] eligible
);
  import isa_pkg::*;

  // row i, column j: entry i blocked by older entry j.
  logic [`ISSUE_DEPTH-1:0] conflict [`ISSUE_DEPTH];

  for (genvar i = 0; i < `ISSUE_DEPTH; i++) begin : g_row
    for (genvar j = 0; j < `ISSUE_DEPTH; j++) begin : g_col
      if (j < i) begin : g_older
        logic raw;
        logic war;
        logic waw;

        assign raw = use_mask[j][USE_RD] &&
                     ((use_mask[i][USE_RS0] && src0[i] == dest[j]) ||
                      (use_mask[i][USE_RS1] && src1[i] == dest[j]));
        assign war = use_mask[i][USE_RD] &&
                     ((use_mask[j][USE_RS0] && src0[j] == dest[i]) ||
                      (use_mask[j][USE_RS1] && src1[j] == dest[i]));
        assign waw = use_mask[i][USE_RD] && use_mask[j][USE_RD] && dest[i] == dest[j];

        assign conflict[i][j] = entry_valid[j] &&
                                (raw || war || waw || is_branch[j] ||
                                 (is_branch[i] && is_cmp[j])); // flags not ready yet.
      end else begin : g_none
        assign conflict[i][j] = 1'b0;
      end
    end

    assign eligible[i] = entry_valid[i] && !(|conflict[i]);
  end

endmodule

// File: rtl/issue_window.sv
`include "issue_settings.svh"

module issue_window (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    in_valid0,
  input  logic                    in_valid1,
  input  isa_pkg::inst_t          in_inst0,
  input  isa_pkg::inst_t          in_inst1,
  input  issue_pkg::pc_t          in_pc0,
  input  issue_pkg::pc_t          in_pc1,
  input  issue_pkg::iid_t         in_iid0,
  input  issue_pkg::iid_t         in_iid1,
  output logic                    in_ready,
  input  logic                    pop0,
  input  logic                    pop1,
  input  issue_pkg::slot_idx_t    pop_slot0,
  input  issue_pkg::slot_idx_t    pop_slot1,
  output logic [`ISSUE_DEPTH-1:0] entry_valid,
  output isa_pkg::inst_t          entry_inst [`ISSUE_DEPTH],
  output issue_pkg::pc_t          entry_pc   [`ISSUE_DEPTH],
  output issue_pkg::iid_t         entry_iid  [`ISSUE_DEPTH]
);
  import isa_pkg::*;
  import issue_pkg::*;

  fill_cnt_t               fill_q;
  fill_cnt_t               wr_ptr;
  logic [`ISSUE_DEPTH-1:0] keep;
  logic                    push0;
  logic                    push1;
  inst_t                   nxt_inst [`ISSUE_DEPTH];
  pc_t                     nxt_pc   [`ISSUE_DEPTH];
  iid_t                    nxt_iid  [`ISSUE_DEPTH];

  assign in_ready = fill_q <= fill_cnt_t'(`ISSUE_DEPTH - 2); // room for a full pair.
  assign push0    = in_valid0 && in_ready;
  assign push1    = in_valid1 && in_ready;

  // entries form a prefix, slot 0 oldest.
  for (genvar i = 0; i < `ISSUE_DEPTH; i++) begin : g_slot
    assign entry_valid[i] = fill_q > fill_cnt_t'(i);
    assign keep[i] = entry_valid[i] && !(pop0 && pop_slot0 == slot_idx_t'(i)) &&
                     !(pop1 && pop_slot1 == slot_idx_t'(i));
  end

  ////////////////////////////////////////////////////////////
  // compact survivors down, then append pushes.
  always_comb begin
    wr_ptr   = '0;
    nxt_inst = entry_inst;
    nxt_pc   = entry_pc;
    nxt_iid  = entry_iid;
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      if (keep[i]) begin
        nxt_inst[slot_idx_t'(wr_ptr)] = entry_inst[i];
        nxt_pc[slot_idx_t'(wr_ptr)]   = entry_pc[i];
        nxt_iid[slot_idx_t'(wr_ptr)]  = entry_iid[i];
        wr_ptr = wr_ptr + 1'b1;
      end
    end
    if (push0) begin
      nxt_inst[slot_idx_t'(wr_ptr)] = in_inst0;
      nxt_pc[slot_idx_t'(wr_ptr)]   = in_pc0;
      nxt_iid[slot_idx_t'(wr_ptr)]  = in_iid0;
      wr_ptr = wr_ptr + 1'b1;
    end
    if (push1) begin
      nxt_inst[slot_idx_t'(wr_ptr)] = in_inst1;
      nxt_pc[slot_idx_t'(wr_ptr)]   = in_pc1;
      nxt_iid[slot_idx_t'(wr_ptr)]  = in_iid1;
      wr_ptr = wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      fill_q <= '0;
    end else begin
      fill_q <= wr_ptr;
    end
  end

  always_ff @(posedge clk) begin
    entry_inst <= nxt_inst;
    entry_pc   <= nxt_pc;
    entry_iid  <= nxt_iid;
  end

endmodule

// File: rtl/operand_decode.sv
module operand_decode (
  input  isa_pkg::inst_t       inst,
  output isa_pkg::reg_idx_t    src0,
  output isa_pkg::reg_idx_t    src1,
  output isa_pkg::reg_idx_t    dest,
  output isa_pkg::reg_use_t    use_mask,
  output isa_pkg::pipe_class_t pipe_class,
  output logic                 is_branch,
  output logic                 is_cmp
);
  import isa_pkg::*;

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = inst[OPCODE_LSB +: $bits(opcode_t)];
  assign rs     = inst[RS_LSB +: $bits(reg_idx_t)];
  assign rt     = inst[RT_LSB +: $bits(reg_idx_t)];
  assign rd     = inst[RD_LSB +: $bits(reg_idx_t)];

  assign is_cmp = (opcode == OP_CMP) || (opcode == OP_TEST) ||
                  (opcode == OP_CMPI) || (opcode == OP_TESTI);
  assign is_branch = (opcode[5:4] == CLASS_BRANCH) && (opcode != OP_JMP); // jmp never blocks.

  always_comb begin
    src0     = '0;
    src1     = '0;
    dest     = '0;
    use_mask = '0;
    if (opcode == OP_JR) begin
      src0             = rs;
      use_mask[USE_RS0] = 1'b1;
    end else if (opcode != OP_NOP) begin
      case (opcode[5:4])
        CLASS_ALU_REG: begin
          src0     = rs;
          src1     = rt;
          dest     = rd;
          use_mask = '1;
        end
        CLASS_ALU_IMM: begin
          src0             = rs;
          dest             = rt;
          use_mask[USE_RS0] = 1'b1;
          use_mask[USE_RD]  = 1'b1;
        end
        CLASS_MEM: begin
          src0             = rs;
          use_mask[USE_RS0] = (opcode == OP_LW) || (opcode == OP_SW);
          if (opcode == OP_LW) begin
            dest            = rt;
            use_mask[USE_RD] = 1'b1;
          end else if (opcode == OP_SW) begin
            src1             = rt;
            use_mask[USE_RS1] = 1'b1;
          end
        end
        default: ; // branches read nothing.
      endcase
    end
  end

  always_comb begin
    if (is_cmp) begin
      pipe_class = PIPE_BRANCH; // flags feed the branch pipe.
    end else if (opcode[5:4] == CLASS_MEM) begin
      pipe_class = PIPE_MEMORY;
    end else if (opcode[5:4] == CLASS_BRANCH) begin
      pipe_class = PIPE_BRANCH;
    end else begin
      pipe_class = PIPE_ANY;
    end
  end

endmodule

// File: rtl/issue_pkg.sv
`include "issue_settings.svh"

package issue_pkg;

  // window position, 0 is oldest.
  typedef logic [$clog2(`ISSUE_DEPTH)-1:0] slot_idx_t;

  // occupancy, 0 to ISSUE_DEPTH.
  typedef logic [$clog2(`ISSUE_DEPTH+1)-1:0] fill_cnt_t;

  typedef logic [`PC_W-1:0]  pc_t;
  typedef logic [`IID_W-1:0] iid_t;

endpackage

// File: rtl/isa_pkg.sv
`include "issue_settings.svh"

package isa_pkg;

  typedef logic [`INST_W-1:0]    inst_t;
  typedef logic [5:0]            opcode_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]            reg_use_t;
  typedef logic [1:0]            pipe_class_t;

  // instruction field positions.
  localparam int OPCODE_LSB = 26;
  localparam int RS_LSB     = 21;
  localparam int RT_LSB     = 16;
  localparam int RD_LSB     = 11;

  localparam int USE_RS0 = 0; // bits of reg_use_t.
  localparam int USE_RS1 = 1;
  localparam int USE_RD  = 2;

  localparam pipe_class_t PIPE_ANY    = 2'd0;
  localparam pipe_class_t PIPE_MEMORY = 2'd1;
  localparam pipe_class_t PIPE_BRANCH = 2'd2;

  // top two opcode bits.
  localparam logic [1:0] CLASS_ALU_REG = 2'b00;
  localparam logic [1:0] CLASS_ALU_IMM = 2'b01;
  localparam logic [1:0] CLASS_MEM     = 2'b10;
  localparam logic [1:0] CLASS_BRANCH  = 2'b11;

  localparam opcode_t OP_NOP   = 6'b000000;
  localparam opcode_t OP_JR    = 6'b001000;
  localparam opcode_t OP_CMP   = 6'b001010;
  localparam opcode_t OP_TEST  = 6'b001011;
  localparam opcode_t OP_CMPI  = 6'b011010;
  localparam opcode_t OP_TESTI = 6'b011011;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;
  localparam opcode_t OP_JMP   = 6'b110000;

endpackage

// File: rtl/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// window geometry.
`define ISSUE_DEPTH 8

////////////////////////////////////////////////////////////
// datapath field widths.
`define INST_W    32
`define PC_W      32
`define IID_W     8
`define REG_IDX_W 5

`endif
